// File: design/mmu_pkg.sv
package mmu_pkg;

    // CP0 register numbers reached through the CP0 write port
    typedef enum logic [4:0] {
        CP0_INDEX    = 5'd0,
        CP0_RANDOM   = 5'd1,
        CP0_ENTRYLO0 = 5'd2,
        CP0_ENTRYLO1 = 5'd3,
        CP0_ENTRYHI  = 5'd10
    } cp0_reg_e;

    typedef enum logic [1:0] {
        TLB_OP_NONE,
        TLB_OP_TLBWI,
        TLB_OP_TLBWR
    } tlb_op_e;

    localparam logic [31:0] TLBWI_INST = 32'h4200_0002;
    localparam logic [31:0] TLBWR_INST = 32'h4200_0006;

    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_e;

    typedef enum logic [1:0] {
        REGION_KSEG0,
        REGION_KSEG1,
        REGION_MAPPED
    } region_e;

    localparam int VPN2_W = 19;
    localparam int ASID_W = 8;
    localparam int PFN_W  = 20;

    // EntryLo holds PFN in 25:6 and V at bit 1, EntryHi holds VPN2 in 31:13 and ASID in 7:0
    localparam int LO_PFN_LSB  = 6;
    localparam int LO_V_BIT    = 1;
    localparam int HI_VPN2_LSB = 13;
    localparam int HI_ASID_LSB = 0;

    localparam logic [31:0] FLASH_BASE   = 32'hBE00_0000;
    localparam logic [31:0] FLASH_LIMIT  = 32'hBEFF_FFFF;
    localparam logic [31:0] ROM_BASE     = 32'hBFC0_0000;
    localparam logic [31:0] ROM_LIMIT    = 32'hBFC0_0FFF;
    localparam logic [31:0] SERIAL_BASE  = 32'hBFD0_03F8;
    localparam logic [31:0] SERIAL_LIMIT = 32'hBFD0_03FC;

endpackage

// File: design/cp0_tlb_decode.sv
`timescale 1ns/1ps

module cp0_tlb_decode #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  logic                                   cp0_we_i,
    input  logic [4:0]                             cp0_addr_i,
    input  logic [31:0]                            cp0_wdata_i,
    input  logic                                   inst_valid_i,
    input  logic [31:0]                            inst_i,
    output logic                                   tlb_we_o,
    output logic [$clog2(TLB_ENTRIES)-1:0]         tlb_widx_o,
    output logic [31:0]                            tlb_whi_o,
    output logic [31:0]                            tlb_wlo0_o,
    output logic [31:0]                            tlb_wlo1_o,
    output logic [mmu_pkg::ASID_W-1:0]             cur_asid_o
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic [IDX_W-1:0]  index_q;
    logic [IDX_W-1:0]  random_q;
    logic [31:0]       entryhi_q;
    logic [31:0]       entrylo0_q;
    logic [31:0]       entrylo1_q;
    mmu_pkg::tlb_op_e  tlb_op;

    always_comb begin
        tlb_op = mmu_pkg::TLB_OP_NONE;
        if (inst_valid_i) begin
            if (inst_i == mmu_pkg::TLBWI_INST) begin
                tlb_op = mmu_pkg::TLB_OP_TLBWI;
            end else if (inst_i == mmu_pkg::TLBWR_INST) begin
                tlb_op = mmu_pkg::TLB_OP_TLBWR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            index_q    <= '0;
            random_q   <= IDX_W'(TLB_ENTRIES - 1);
            entryhi_q  <= '0;
            entrylo0_q <= '0;
            entrylo1_q <= '0;
        end else begin
            // Random counts down and wraps to the top slot
            if (tlb_op == mmu_pkg::TLB_OP_TLBWR) begin
                if (random_q == '0) begin
                    random_q <= IDX_W'(TLB_ENTRIES - 1);
                end else begin
                    random_q <= random_q - 1'b1;
                end
            end
            // a CP0 write to Random in the same cycle overrides the decrement
            if (cp0_we_i) begin
                case (cp0_addr_i)
                    mmu_pkg::CP0_INDEX:    index_q    <= cp0_wdata_i[IDX_W-1:0];
                    mmu_pkg::CP0_RANDOM:   random_q   <= cp0_wdata_i[IDX_W-1:0];
                    mmu_pkg::CP0_ENTRYHI:  entryhi_q  <= cp0_wdata_i;
                    mmu_pkg::CP0_ENTRYLO0: entrylo0_q <= cp0_wdata_i;
                    mmu_pkg::CP0_ENTRYLO1: entrylo1_q <= cp0_wdata_i;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            tlb_we_o <= 1'b0;
        end else begin
            tlb_we_o <= (tlb_op != mmu_pkg::TLB_OP_NONE);
        end
    end

    // the request carries the register values from before this edge
    always_ff @(posedge clk) begin
        if (tlb_op != mmu_pkg::TLB_OP_NONE) begin
            tlb_widx_o <= (tlb_op == mmu_pkg::TLB_OP_TLBWR) ? random_q : index_q;
            tlb_whi_o  <= entryhi_q;
            tlb_wlo0_o <= entrylo0_q;
            tlb_wlo1_o <= entrylo1_q;
        end
    end

    assign cur_asid_o = entryhi_q[mmu_pkg::HI_ASID_LSB +: mmu_pkg::ASID_W];

    a_we_spacing: assert property (@(posedge clk) disable iff (rst_i)
        (tlb_we_o && $past(tlb_we_o)) |->
            ($past(inst_valid_i && (inst_i == mmu_pkg::TLBWI_INST ||
                                    inst_i == mmu_pkg::TLBWR_INST), 1) &&
             $past(inst_valid_i && (inst_i == mmu_pkg::TLBWI_INST ||
                                    inst_i == mmu_pkg::TLBWR_INST), 2)));

endmodule

// File: design/tlb_array.sv
`timescale 1ns/1ps

module tlb_array #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               tlb_we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0]     tlb_widx_i,
    input  logic [31:0]                        tlb_whi_i,
    input  logic [31:0]                        tlb_wlo0_i,
    input  logic [31:0]                        tlb_wlo1_i,
    input  logic [mmu_pkg::ASID_W-1:0]         cur_asid_i,
    input  logic                               wb_cyc_i,
    input  logic                               wb_stb_i,
    input  logic [31:0]                        wb_adr_i,
    input  logic                               wb_ack_i,
    output logic                               lk_vld_o,
    output logic [31:0]                        lk_vaddr_o,
    output logic                               lk_hit_o,
    output logic [31:0]                        lk_paddr_o
);

    logic [mmu_pkg::VPN2_W-1:0] vpn2_q [TLB_ENTRIES];
    logic [mmu_pkg::ASID_W-1:0] asid_q [TLB_ENTRIES];
    logic [mmu_pkg::PFN_W-1:0]  pfn0_q [TLB_ENTRIES];
    logic [mmu_pkg::PFN_W-1:0]  pfn1_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0]     v0_q;
    logic [TLB_ENTRIES-1:0]     v1_q;

    logic                       busy_q;
    logic                       accept;
    logic                       odd_page;
    logic                       match_hit;
    logic [mmu_pkg::PFN_W-1:0]  match_pfn;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            v0_q <= '0;
            v1_q <= '0;
        end else if (tlb_we_i) begin
            v0_q[tlb_widx_i] <= tlb_wlo0_i[mmu_pkg::LO_V_BIT];
            v1_q[tlb_widx_i] <= tlb_wlo1_i[mmu_pkg::LO_V_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we_i) begin
            vpn2_q[tlb_widx_i] <= tlb_whi_i[mmu_pkg::HI_VPN2_LSB +: mmu_pkg::VPN2_W];
            asid_q[tlb_widx_i] <= tlb_whi_i[mmu_pkg::HI_ASID_LSB +: mmu_pkg::ASID_W];
            pfn0_q[tlb_widx_i] <= tlb_wlo0_i[mmu_pkg::LO_PFN_LSB +: mmu_pkg::PFN_W];
            pfn1_q[tlb_widx_i] <= tlb_wlo1_i[mmu_pkg::LO_PFN_LSB +: mmu_pkg::PFN_W];
        end
    end

    // bit 12 picks the odd page of the pair
    assign odd_page = wb_adr_i[mmu_pkg::HI_VPN2_LSB-1];
    assign accept   = wb_cyc_i && wb_stb_i && !busy_q;

    // scanning downwards lets the lowest matching entry win
    always_comb begin
        match_hit = 1'b0;
        match_pfn = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (vpn2_q[i] == wb_adr_i[mmu_pkg::HI_VPN2_LSB +: mmu_pkg::VPN2_W] &&
                asid_q[i] == cur_asid_i &&
                (odd_page ? v1_q[i] : v0_q[i])) begin
                match_hit = 1'b1;
                match_pfn = odd_page ? pfn1_q[i] : pfn0_q[i];
            end
        end
    end

    // busy also drops when the master abandons the cycle before the ack
    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q   <= 1'b0;
            lk_vld_o <= 1'b0;
        end else begin
            lk_vld_o <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (wb_ack_i || !wb_cyc_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lk_vaddr_o <= wb_adr_i;
            lk_hit_o   <= match_hit;
            lk_paddr_o <= {match_pfn, wb_adr_i[mmu_pkg::HI_VPN2_LSB-2:0]};
        end
    end

    a_lk_strobe: assert property (@(posedge clk) disable iff (rst_i)
        lk_vld_o |=> !lk_vld_o);

endmodule

// File: design/addr_region_map.sv
`timescale 1ns/1ps

module addr_region_map (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        wb_cyc_i,
    input  logic        lk_vld_i,
    input  logic [31:0] lk_vaddr_i,
    input  logic        lk_hit_i,
    input  logic [31:0] lk_paddr_i,
    output logic        wb_ack_o,
    output logic [31:0] wb_dat_o,
    output logic        hit_o,
    output logic        sram_ce_o,
    output logic        flash_ce_o,
    output logic        rom_ce_o,
    output logic        serial_ce_o
);

    mmu_pkg::wb_state_e state_q;
    mmu_pkg::region_e   region;
    logic               nxt_hit;
    logic [31:0]        nxt_paddr;
    logic               nxt_sram;
    logic               nxt_flash;
    logic               nxt_rom;
    logic               nxt_serial;

    function automatic logic in_window(input logic [31:0] addr, input logic [31:0] base,
                                       input logic [31:0] limit);
        return (addr >= base) && (addr <= limit);
    endfunction

    always_comb begin
        case (lk_vaddr_i[31:29])
            3'b100:  region = mmu_pkg::REGION_KSEG0;
            3'b101:  region = mmu_pkg::REGION_KSEG1;
            default: region = mmu_pkg::REGION_MAPPED;
        endcase
    end

    always_comb begin
        nxt_hit    = 1'b0;
        nxt_paddr  = '0;
        nxt_sram   = 1'b0;
        nxt_flash  = 1'b0;
        nxt_rom    = 1'b0;
        nxt_serial = 1'b0;
        case (region)
            mmu_pkg::REGION_KSEG0: begin
                nxt_hit   = 1'b1;
                nxt_paddr = {1'b0, lk_vaddr_i[30:0]};
            end
            mmu_pkg::REGION_KSEG1: begin
                nxt_hit    = 1'b1;
                nxt_paddr  = {3'b000, lk_vaddr_i[28:0]};
                nxt_flash  = in_window(lk_vaddr_i, mmu_pkg::FLASH_BASE, mmu_pkg::FLASH_LIMIT);
                nxt_rom    = in_window(lk_vaddr_i, mmu_pkg::ROM_BASE, mmu_pkg::ROM_LIMIT);
                nxt_serial = in_window(lk_vaddr_i, mmu_pkg::SERIAL_BASE, mmu_pkg::SERIAL_LIMIT);
            end
            default: begin
                // a TLB miss leaves the data at zero
                nxt_hit   = lk_hit_i;
                nxt_paddr = lk_hit_i ? lk_paddr_i : '0;
                nxt_sram  = lk_hit_i;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= mmu_pkg::WB_IDLE;
            wb_ack_o    <= 1'b0;
            hit_o       <= 1'b0;
            sram_ce_o   <= 1'b0;
            flash_ce_o  <= 1'b0;
            rom_ce_o    <= 1'b0;
            serial_ce_o <= 1'b0;
        end else begin
            case (state_q)
                mmu_pkg::WB_IDLE: begin
                    // no ack if the master has already left the cycle
                    if (lk_vld_i && wb_cyc_i) begin
                        state_q     <= mmu_pkg::WB_ACK;
                        wb_ack_o    <= 1'b1;
                        hit_o       <= nxt_hit;
                        sram_ce_o   <= nxt_sram;
                        flash_ce_o  <= nxt_flash;
                        rom_ce_o    <= nxt_rom;
                        serial_ce_o <= nxt_serial;
                    end
                end
                default: begin
                    state_q     <= mmu_pkg::WB_IDLE;
                    wb_ack_o    <= 1'b0;
                    hit_o       <= 1'b0;
                    sram_ce_o   <= 1'b0;
                    flash_ce_o  <= 1'b0;
                    rom_ce_o    <= 1'b0;
                    serial_ce_o <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == mmu_pkg::WB_IDLE && lk_vld_i) begin
            wb_dat_o <= nxt_paddr;
        end
    end

    a_one_ce: assert property (@(posedge clk) disable iff (rst_i)
        (|{sram_ce_o, flash_ce_o, rom_ce_o, serial_ce_o}) |->
            (wb_ack_o && $onehot({sram_ce_o, flash_ce_o, rom_ce_o, serial_ce_o})));

    a_ack_cyc: assert property (@(posedge clk) disable iff (rst_i)
        wb_ack_o |-> wb_cyc_i);

endmodule

// File: design/mmu_top.sv
`timescale 1ns/1ps

module mmu_top #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        cp0_we_i,
    input  logic [4:0]  cp0_addr_i,
    input  logic [31:0] cp0_wdata_i,
    input  logic        inst_valid_i,
    input  logic [31:0] inst_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic [31:0] wb_adr_i,
    output logic        wb_ack_o,
    output logic [31:0] wb_dat_o,
    output logic        hit_o,
    output logic        sram_ce_o,
    output logic        flash_ce_o,
    output logic        rom_ce_o,
    output logic        serial_ce_o
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic                       tlb_we;
    logic [IDX_W-1:0]           tlb_widx;
    logic [31:0]                tlb_whi;
    logic [31:0]                tlb_wlo0;
    logic [31:0]                tlb_wlo1;
    logic [mmu_pkg::ASID_W-1:0] cur_asid;

    logic                       lk_vld;
    logic [31:0]                lk_vaddr;
    logic                       lk_hit;
    logic [31:0]                lk_paddr;

    cp0_tlb_decode #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_decode (
        .clk          (clk),
        .rst_i        (rst_i),
        .cp0_we_i     (cp0_we_i),
        .cp0_addr_i   (cp0_addr_i),
        .cp0_wdata_i  (cp0_wdata_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .tlb_we_o     (tlb_we),
        .tlb_widx_o   (tlb_widx),
        .tlb_whi_o    (tlb_whi),
        .tlb_wlo0_o   (tlb_wlo0),
        .tlb_wlo1_o   (tlb_wlo1),
        .cur_asid_o   (cur_asid)
    );

    tlb_array #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_tlb (
        .clk        (clk),
        .rst_i      (rst_i),
        .tlb_we_i   (tlb_we),
        .tlb_widx_i (tlb_widx),
        .tlb_whi_i  (tlb_whi),
        .tlb_wlo0_i (tlb_wlo0),
        .tlb_wlo1_i (tlb_wlo1),
        .cur_asid_i (cur_asid),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_adr_i   (wb_adr_i),
        .wb_ack_i   (wb_ack_o),
        .lk_vld_o   (lk_vld),
        .lk_vaddr_o (lk_vaddr),
        .lk_hit_o   (lk_hit),
        .lk_paddr_o (lk_paddr)
    );

    addr_region_map u_region (
        .clk         (clk),
        .rst_i       (rst_i),
        .wb_cyc_i    (wb_cyc_i),
        .lk_vld_i    (lk_vld),
        .lk_vaddr_i  (lk_vaddr),
        .lk_hit_i    (lk_hit),
        .lk_paddr_i  (lk_paddr),
        .wb_ack_o    (wb_ack_o),
        .wb_dat_o    (wb_dat_o),
        .hit_o       (hit_o),
        .sram_ce_o   (sram_ce_o),
        .flash_ce_o  (flash_ce_o),
        .rom_ce_o    (rom_ce_o),
        .serial_ce_o (serial_ce_o)
    );

endmodule

// File: testbench/tb_mmu.sv
`timescale 1ns/1ps

module tb_mmu;

    localparam int TLB_ENTRIES = 16;
    localparam int IDX_W       = $clog2(TLB_ENTRIES);
    localparam int ACK_TIMEOUT = 20;

    // direct-mapped addresses with each device window probed at and just past both edges
    localparam logic [31:0] REGION_ADDRS [16] = '{
        32'h8000_0000, 32'h9FFF_FFFC, 32'hA000_1000, 32'hBFFF_FFFF,
        mmu_pkg::FLASH_BASE - 32'd1, mmu_pkg::FLASH_BASE,
        mmu_pkg::FLASH_LIMIT, mmu_pkg::FLASH_LIMIT + 32'd1,
        mmu_pkg::ROM_BASE - 32'd1, mmu_pkg::ROM_BASE,
        mmu_pkg::ROM_LIMIT, mmu_pkg::ROM_LIMIT + 32'd1,
        mmu_pkg::SERIAL_BASE - 32'd1, mmu_pkg::SERIAL_BASE,
        mmu_pkg::SERIAL_LIMIT, mmu_pkg::SERIAL_LIMIT + 32'd1
    };

    typedef struct packed {
        logic        hit;
        logic        sram;
        logic        flash;
        logic        rom;
        logic        serial;
        logic [31:0] paddr;
    } xlate_t;

    logic        clk;
    logic        rst_i;
    logic        cp0_we_i;
    logic [4:0]  cp0_addr_i;
    logic [31:0] cp0_wdata_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic [31:0] wb_adr_i;
    logic        wb_ack_o;
    logic [31:0] wb_dat_o;
    logic        hit_o;
    logic        sram_ce_o;
    logic        flash_ce_o;
    logic        rom_ce_o;
    logic        serial_ce_o;

    // model copy of the CP0 registers and the TLB entries
    logic [IDX_W-1:0] m_index;
    logic [IDX_W-1:0] m_random;
    logic [31:0]      m_hi;
    logic [31:0]      m_lo0;
    logic [31:0]      m_lo1;
    logic [18:0]      m_vpn2 [TLB_ENTRIES];
    logic [7:0]       m_asid [TLB_ENTRIES];
    logic [19:0]      m_pfn0 [TLB_ENTRIES];
    logic [19:0]      m_pfn1 [TLB_ENTRIES];
    logic             m_v0   [TLB_ENTRIES];
    logic             m_v1   [TLB_ENTRIES];

    logic [15:0] lfsr_state;
    logic [31:0] pending_q [$];
    logic [7:0]  asid_a;
    logic [18:0] old_vpn2 [3];
    logic [18:0] new_vpn2 [5];

    mmu_top #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_mmu_top (
        .clk          (clk),
        .rst_i        (rst_i),
        .cp0_we_i     (cp0_we_i),
        .cp0_addr_i   (cp0_addr_i),
        .cp0_wdata_i  (cp0_wdata_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_adr_i     (wb_adr_i),
        .wb_ack_o     (wb_ack_o),
        .wb_dat_o     (wb_dat_o),
        .hit_o        (hit_o),
        .sram_ce_o    (sram_ce_o),
        .flash_ce_o   (flash_ce_o),
        .rom_ce_o     (rom_ce_o),
        .serial_ce_o  (serial_ce_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic xlate_t translate(input logic [31:0] vaddr);
        xlate_t           r;
        mmu_pkg::region_e region;
        logic             odd;
        r   = '0;
        odd = vaddr[12];
        case (vaddr[31:29])
            3'b100:  region = mmu_pkg::REGION_KSEG0;
            3'b101:  region = mmu_pkg::REGION_KSEG1;
            default: region = mmu_pkg::REGION_MAPPED;
        endcase
        case (region)
            mmu_pkg::REGION_KSEG0: begin
                r.hit   = 1'b1;
                r.paddr = vaddr & 32'h7FFF_FFFF;
            end
            mmu_pkg::REGION_KSEG1: begin
                r.hit    = 1'b1;
                r.paddr  = vaddr & 32'h1FFF_FFFF;
                r.flash  = vaddr >= mmu_pkg::FLASH_BASE && vaddr <= mmu_pkg::FLASH_LIMIT;
                r.rom    = vaddr >= mmu_pkg::ROM_BASE && vaddr <= mmu_pkg::ROM_LIMIT;
                r.serial = vaddr >= mmu_pkg::SERIAL_BASE && vaddr <= mmu_pkg::SERIAL_LIMIT;
            end
            default: begin
                // first valid match from index 0 upward wins
                for (int i = 0; i < TLB_ENTRIES; i++) begin
                    if (!r.hit && m_vpn2[i] == vaddr[31:13] && m_asid[i] == m_hi[7:0] &&
                        (odd ? m_v1[i] : m_v0[i])) begin
                        r.hit   = 1'b1;
                        r.sram  = 1'b1;
                        r.paddr = {(odd ? m_pfn1[i] : m_pfn0[i]), vaddr[11:0]};
                    end
                end
            end
        endcase
        return r;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_addr(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic cp0_write(input mmu_pkg::cp0_reg_e num, input logic [31:0] data);
        @(posedge clk);
        cp0_we_i    <= 1'b1;
        cp0_addr_i  <= num;
        cp0_wdata_i <= data;
        @(posedge clk);
        cp0_we_i    <= 1'b0;
        case (num)
            mmu_pkg::CP0_INDEX:    m_index  = IDX_W'(data % TLB_ENTRIES);
            mmu_pkg::CP0_RANDOM:   m_random = IDX_W'(data % TLB_ENTRIES);
            mmu_pkg::CP0_ENTRYHI:  m_hi     = data;
            mmu_pkg::CP0_ENTRYLO0: m_lo0    = data;
            mmu_pkg::CP0_ENTRYLO1: m_lo1    = data;
            default: ;
        endcase
    endtask

    task automatic issue_tlb_inst(input logic [31:0] inst);
        int slot;
        @(posedge clk);
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        @(posedge clk);
        inst_valid_i <= 1'b0;
        slot = (inst == mmu_pkg::TLBWR_INST) ? int'(m_random) : int'(m_index);
        m_vpn2[slot] = m_hi[31:13];
        m_asid[slot] = m_hi[7:0];
        m_pfn0[slot] = m_lo0[25:6];
        m_pfn1[slot] = m_lo1[25:6];
        m_v0[slot]   = m_lo0[1];
        m_v1[slot]   = m_lo1[1];
        if (inst == mmu_pkg::TLBWR_INST) begin
            if (m_random == '0) begin
                m_random = IDX_W'(TLB_ENTRIES - 1);
            end else begin
                m_random = m_random - 1'b1;
            end
        end
    endtask

    task automatic program_entry(input logic use_random, input logic [IDX_W-1:0] idx,
                                 input logic [18:0] vpn2, input logic [7:0] asid,
                                 input logic [19:0] pfn0, input logic v0,
                                 input logic [19:0] pfn1, input logic v1);
        if (!use_random) begin
            cp0_write(mmu_pkg::CP0_INDEX, 32'(idx));
        end
        cp0_write(mmu_pkg::CP0_ENTRYHI, {vpn2, 5'd0, asid});
        cp0_write(mmu_pkg::CP0_ENTRYLO0, {6'd0, pfn0, 4'd0, v0, 1'b0});
        cp0_write(mmu_pkg::CP0_ENTRYLO1, {6'd0, pfn1, 4'd0, v1, 1'b0});
        issue_tlb_inst(use_random ? mmu_pkg::TLBWR_INST : mmu_pkg::TLBWI_INST);
    endtask

    // stb drops on the edge after the ack and cyc stays up for a back-to-back request
    task automatic wishbone_read(input logic [31:0] addr, input logic keep_cyc);
        int waited;
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_adr_i <= addr;
        pending_q.push_back(addr);
        waited = 0;
        @(negedge clk);
        while (!wb_ack_o) begin
            if (waited == ACK_TIMEOUT) begin
                stop_on_error($sformatf("no acknowledge within %0d cycles for address 0x%08h",
                                        ACK_TIMEOUT, addr));
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        wb_stb_i <= 1'b0;
        wb_cyc_i <= keep_cyc;
    endtask

    task automatic lookup_page(input logic [18:0] vpn2, input logic odd, input logic keep_cyc);
        wishbone_read({vpn2, odd, 12'(rand_bits(12))}, keep_cyc);
    endtask

    // outputs are checked mid-cycle away from the edge where they change
    always @(negedge clk) begin : check_outputs
        xlate_t exp;
        if (!rst_i) begin
            if (wb_ack_o) begin
                if (pending_q.size() == 0) begin
                    stop_on_error("acknowledge seen with no request outstanding");
                end else begin
                    exp = translate(pending_q.pop_front());
                    compare_addr("wb_dat_o", wb_dat_o, exp.paddr);
                    compare_bit("hit_o", hit_o, exp.hit);
                    compare_bit("sram_ce_o", sram_ce_o, exp.sram);
                    compare_bit("flash_ce_o", flash_ce_o, exp.flash);
                    compare_bit("rom_ce_o", rom_ce_o, exp.rom);
                    compare_bit("serial_ce_o", serial_ce_o, exp.serial);
                end
            end else begin
                compare_bit("hit_o", hit_o, 1'b0);
                compare_bit("sram_ce_o", sram_ce_o, 1'b0);
                compare_bit("flash_ce_o", flash_ce_o, 1'b0);
                compare_bit("rom_ce_o", rom_ce_o, 1'b0);
                compare_bit("serial_ce_o", serial_ce_o, 1'b0);
            end
        end
    end

    initial begin
        lfsr_state   = 16'd56717;
        m_index      = '0;
        m_random     = IDX_W'(TLB_ENTRIES - 1);
        m_hi         = '0;
        m_lo0        = '0;
        m_lo1        = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            m_vpn2[i] = '0;
            m_asid[i] = '0;
            m_pfn0[i] = '0;
            m_pfn1[i] = '0;
            m_v0[i]   = 1'b0;
            m_v1[i]   = 1'b0;
        end
        rst_i        = 1'b1;
        cp0_we_i     = 1'b0;
        cp0_addr_i   = '0;
        cp0_wdata_i  = '0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_adr_i     = '0;
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;

        // the checker flags any stray ack or enable while the port is quiet after reset
        repeat (10) @(posedge clk);

        for (int i = 0; i < 16; i++) begin
            wishbone_read(REGION_ADDRS[i], 1'b0);
        end

        // TLBWI writes fixed slots and the middle entry has only its even page valid
        asid_a = 8'(rand_bits(8));
        for (int k = 0; k < 3; k++) begin
            old_vpn2[k] = {1'b0, 18'(rand_bits(18))};
            program_entry(1'b0, IDX_W'(2 + 3 * k + (k == 2 ? 1 : 0)), old_vpn2[k], asid_a,
                          20'(rand_bits(20)), 1'b1, 20'(rand_bits(20)), k != 1);
        end
        for (int k = 0; k < 3; k++) begin
            lookup_page(old_vpn2[k], 1'b0, 1'b0);
            lookup_page(old_vpn2[k], 1'b1, 1'b0);
        end

        cp0_write(mmu_pkg::CP0_ENTRYHI, {old_vpn2[0], 5'd0, asid_a ^ 8'h5A});
        lookup_page(old_vpn2[0], 1'b0, 1'b0);
        cp0_write(mmu_pkg::CP0_ENTRYHI, {old_vpn2[0], 5'd0, asid_a});

        // 0x13 loads Random with 3 so the writes land in 3, 2, 1 and 0 and then wrap to 15
        cp0_write(mmu_pkg::CP0_RANDOM, 32'h0000_0013);
        for (int k = 0; k < 5; k++) begin
            new_vpn2[k] = {1'b0, 18'(rand_bits(18))};
            program_entry(1'b1, '0, new_vpn2[k], asid_a,
                          20'(rand_bits(20)), 1'b1, 20'(rand_bits(20)), 1'b1);
        end
        lookup_page(old_vpn2[0], 1'b0, 1'b0);
        lookup_page(old_vpn2[2], 1'b1, 1'b0);
        for (int k = 0; k < 5; k++) begin
            lookup_page(new_vpn2[k], 1'b0, 1'b0);
        end

        for (int k = 0; k < 5; k++) begin
            lookup_page(new_vpn2[k], 1'b1, 1'b1);
        end
        wishbone_read(mmu_pkg::ROM_BASE + 32'd4, 1'b1);
        wishbone_read(mmu_pkg::SERIAL_BASE, 1'b1);
        lookup_page(old_vpn2[1], 1'b1, 1'b0);

        repeat (3) @(posedge clk);
        $display("test passed");
        $finish;
    end

endmodule

// File: tb.f
design/mmu_pkg.sv
design/cp0_tlb_decode.sv
design/tlb_array.sv
design/addr_region_map.sv
design/mmu_top.sv
testbench/tb_mmu.sv

// File: Makefile
# Verilator build and run for the MMU testbench

VERILATOR ?= verilator
TOP       ?= tb_mmu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the binary exits with a failing status when the testbench stops on $fatal
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
